//--- cpu_pkg.sv
package cpu_pkg;

    // datapath width, also the address width
    localparam int XLEN    = 32;

    // general register file geometry
    localparam int REG_NUM = 32;
    localparam int REG_AW  = 5;

    // add.w is matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W  = 17'h0_0020;

    // addi.w, ld.w and st.w are matched on inst[31:22]
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;

    // beq is matched on inst[31:26]
    localparam logic [5:0]  OP_BEQ    = 6'h16;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // pc and instruction word
    localparam int FS_DS_W = 2 * cpu_pkg::XLEN;
    // pc, src1, src2, store data, dest, load, store, write enable
    localparam int DS_ES_W = 4 * cpu_pkg::XLEN + cpu_pkg::REG_AW + 3;
    // pc, result, dest, load, write enable
    localparam int ES_MS_W = 2 * cpu_pkg::XLEN + cpu_pkg::REG_AW + 2;
    // pc, final data, dest, write enable
    localparam int MS_WS_W = 2 * cpu_pkg::XLEN + cpu_pkg::REG_AW + 1;
    // taken flag and target
    localparam int BR_W    = cpu_pkg::XLEN + 1;
    // write enable, register number, data
    localparam int RF_W    = 1 + cpu_pkg::REG_AW + cpu_pkg::XLEN;

endpackage

//--- if_stage.sv
`timescale 1ns/10ps

module if_stage #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ds_allowin,
    input  logic [bus_pkg::BR_W-1:0]    br_bus,
    output logic                        fs_to_ds_valid,
    output logic [bus_pkg::FS_DS_W-1:0] fs_to_ds_bus,
    output logic                        inst_sram_en,
    output logic [cpu_pkg::XLEN-1:0]    inst_sram_addr,
    input  logic [cpu_pkg::XLEN-1:0]    inst_sram_rdata
);

    logic                     fs_valid;
    logic                     fs_allowin;
    logic                     br_taken;
    logic                     inst_buf_valid;
    logic [cpu_pkg::XLEN-1:0] br_target;
    logic [cpu_pkg::XLEN-1:0] fs_pc;
    logic [cpu_pkg::XLEN-1:0] nextpc;
    logic [cpu_pkg::XLEN-1:0] fs_inst;
    logic [cpu_pkg::XLEN-1:0] inst_buf;

    assign {br_taken, br_target} = br_bus;

    // the request for nextpc goes out while fs_pc is still the previous one
    assign nextpc         = br_taken ? br_target : fs_pc + 32'd4;
    assign fs_allowin     = !fs_valid || ds_allowin;
    assign inst_sram_en   = fs_allowin;
    assign inst_sram_addr = nextpc;

    // the word after a taken beq is dropped here
    assign fs_to_ds_valid = fs_valid && !br_taken;
    assign fs_to_ds_bus   = {fs_pc, fs_inst};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fs_valid <= 1'b0;
            fs_pc    <= RESET_PC - 32'd4;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
            fs_pc    <= nextpc;
        end
    end

    // keep the fetched word while decode stalls, the sram is not re-read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_allowin) begin
            inst_buf_valid <= 1'b0;
        end else begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fs_allowin && !inst_buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

    // branch targets from decode must stay on word boundaries too
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00);

endmodule

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        es_allowin,
    input  logic                        fs_to_ds_valid,
    input  logic [bus_pkg::FS_DS_W-1:0] fs_to_ds_bus,
    input  logic [cpu_pkg::REG_AW-1:0]  es_dest,
    input  logic [cpu_pkg::REG_AW-1:0]  ms_dest,
    output logic                        ds_allowin,
    output logic                        ds_to_es_valid,
    output logic [bus_pkg::DS_ES_W-1:0] ds_to_es_bus,
    output logic [bus_pkg::BR_W-1:0]    br_bus,
    output logic [cpu_pkg::REG_AW-1:0]  rf_raddr1,
    output logic [cpu_pkg::REG_AW-1:0]  rf_raddr2,
    input  logic [cpu_pkg::XLEN-1:0]    rf_rdata1,
    input  logic [cpu_pkg::XLEN-1:0]    rf_rdata2
);

    logic                        ds_valid;
    logic [bus_pkg::FS_DS_W-1:0] ds_bus_r;
    logic [cpu_pkg::XLEN-1:0]    ds_pc;
    logic [cpu_pkg::XLEN-1:0]    ds_inst;
    logic [cpu_pkg::REG_AW-1:0]  rd;
    logic [cpu_pkg::REG_AW-1:0]  rj;
    logic [cpu_pkg::REG_AW-1:0]  rk;
    logic [cpu_pkg::REG_AW-1:0]  dest;
    logic [11:0]                 si12;
    logic [15:0]                 offs16;
    logic                        inst_add_w;
    logic                        inst_addi_w;
    logic                        inst_ld_w;
    logic                        inst_st_w;
    logic                        inst_beq;
    logic                        src1_used;
    logic                        src2_used;
    logic                        gr_we;
    logic                        ds_stall;
    logic                        ds_ready_go;
    logic                        br_taken;
    logic [cpu_pkg::XLEN-1:0]    src2;
    logic [cpu_pkg::XLEN-1:0]    br_target;

    assign {ds_pc, ds_inst} = ds_bus_r;

    assign rd     = ds_inst[4:0];
    assign rj     = ds_inst[9:5];
    assign rk     = ds_inst[14:10];
    assign si12   = ds_inst[21:10];
    assign offs16 = ds_inst[25:10];

    assign inst_add_w  = ds_inst[31:15] == cpu_pkg::OP_ADD_W;
    assign inst_addi_w = ds_inst[31:22] == cpu_pkg::OP_ADDI_W;
    assign inst_ld_w   = ds_inst[31:22] == cpu_pkg::OP_LD_W;
    assign inst_st_w   = ds_inst[31:22] == cpu_pkg::OP_ST_W;
    assign inst_beq    = ds_inst[31:26] == cpu_pkg::OP_BEQ;

    // port 2 reads rk for add.w, rd for st.w data and beq
    assign rf_raddr1 = rj;
    assign rf_raddr2 = inst_add_w ? rk : rd;
    assign src1_used = inst_add_w || inst_addi_w || inst_ld_w || inst_st_w || inst_beq;
    assign src2_used = inst_add_w || inst_st_w || inst_beq;

    // r0 destinations are turned into non-writing ops right here
    assign gr_we = (inst_add_w || inst_addi_w || inst_ld_w) && rd != '0;
    assign dest  = gr_we ? rd : '0;
    assign src2  = inst_add_w ? rf_rdata2 : {{20{si12[11]}}, si12};

    // no forwarding, wait until the producer reaches writeback
    assign ds_stall = ds_valid && (
        (src1_used && rf_raddr1 != '0 && (rf_raddr1 == es_dest || rf_raddr1 == ms_dest)) ||
        (src2_used && rf_raddr2 != '0 && (rf_raddr2 == es_dest || rf_raddr2 == ms_dest)));
    assign ds_ready_go    = !ds_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign br_target = ds_pc + {{14{offs16[15]}}, offs16, 2'b00};
    assign br_taken  = ds_valid && inst_beq && ds_ready_go && es_allowin
                       && rf_rdata1 == rf_rdata2;
    assign br_bus    = {br_taken, br_target};

    assign ds_to_es_bus = {ds_pc, rf_rdata1, src2, rf_rdata2, dest,
                           inst_ld_w, inst_st_w, gr_we};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus_r <= fs_to_ds_bus;
        end
    end

    // producers drain from execute and memory, so a stall ends within two cycles
    a_stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        (ds_stall && $past(ds_stall)) |=> !ds_stall);

endmodule

//--- regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [bus_pkg::RF_W-1:0]   rf_bus,
    input  logic [cpu_pkg::REG_AW-1:0] raddr1,
    input  logic [cpu_pkg::REG_AW-1:0] raddr2,
    output logic [cpu_pkg::XLEN-1:0]   rdata1,
    output logic [cpu_pkg::XLEN-1:0]   rdata2
);

    logic [cpu_pkg::XLEN-1:0]   rf [cpu_pkg::REG_NUM];
    logic                       we;
    logic [cpu_pkg::REG_AW-1:0] waddr;
    logic [cpu_pkg::XLEN-1:0]   wdata;

    assign {we, waddr, wdata} = rf_bus;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_pkg::REG_NUM; i++) begin
                rf[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // write-first, so decode sees a same-cycle writeback
    assign rdata1 = (raddr1 == '0) ? '0 : (we && waddr == raddr1) ? wdata : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (we && waddr == raddr2) ? wdata : rf[raddr2];

endmodule

//--- exe_stage.sv
`timescale 1ns/10ps

module exe_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ms_allowin,
    input  logic                        ds_to_es_valid,
    input  logic [bus_pkg::DS_ES_W-1:0] ds_to_es_bus,
    output logic                        es_allowin,
    output logic                        es_to_ms_valid,
    output logic [bus_pkg::ES_MS_W-1:0] es_to_ms_bus,
    output logic [cpu_pkg::REG_AW-1:0]  es_dest,
    output logic                        data_sram_en,
    output logic [3:0]                  data_sram_we,
    output logic [cpu_pkg::XLEN-1:0]    data_sram_addr,
    output logic [cpu_pkg::XLEN-1:0]    data_sram_wdata
);

    logic                        es_valid;
    logic                        es_mem_go;
    logic [bus_pkg::DS_ES_W-1:0] es_bus_r;
    logic [cpu_pkg::XLEN-1:0]    es_pc;
    logic [cpu_pkg::XLEN-1:0]    es_src1;
    logic [cpu_pkg::XLEN-1:0]    es_src2;
    logic [cpu_pkg::XLEN-1:0]    es_st_data;
    logic [cpu_pkg::XLEN-1:0]    es_result;
    logic [cpu_pkg::REG_AW-1:0]  es_dest_r;
    logic                        es_load;
    logic                        es_store;
    logic                        es_gr_we;

    assign {es_pc, es_src1, es_src2, es_st_data, es_dest_r,
            es_load, es_store, es_gr_we} = es_bus_r;

    // single cycle stage, always ready to go
    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    // one adder for add.w, addi.w and the load/store address
    assign es_result    = es_src1 + es_src2;
    assign es_to_ms_bus = {es_pc, es_result, es_dest_r, es_load, es_gr_we};
    assign es_dest      = (es_valid && es_gr_we) ? es_dest_r : '0;

    // access only when the op actually moves into memory
    assign es_mem_go       = es_to_ms_valid && ms_allowin;
    assign data_sram_en    = es_mem_go && (es_load || es_store);
    assign data_sram_we    = (es_mem_go && es_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = es_result;
    assign data_sram_wdata = es_st_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus_r <= ds_to_es_bus;
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ws_allowin,
    input  logic                        es_to_ms_valid,
    input  logic [bus_pkg::ES_MS_W-1:0] es_to_ms_bus,
    input  logic [cpu_pkg::XLEN-1:0]    data_sram_rdata,
    output logic                        ms_allowin,
    output logic                        ms_to_ws_valid,
    output logic [bus_pkg::MS_WS_W-1:0] ms_to_ws_bus,
    output logic [cpu_pkg::REG_AW-1:0]  ms_dest
);

    logic                        ms_valid;
    logic [bus_pkg::ES_MS_W-1:0] ms_bus_r;
    logic [cpu_pkg::XLEN-1:0]    ms_pc;
    logic [cpu_pkg::XLEN-1:0]    ms_result;
    logic [cpu_pkg::XLEN-1:0]    ms_final;
    logic [cpu_pkg::REG_AW-1:0]  ms_dest_r;
    logic                        ms_load;
    logic                        ms_gr_we;

    assign {ms_pc, ms_result, ms_dest_r, ms_load, ms_gr_we} = ms_bus_r;

    // single cycle stage, always ready to go
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    // load data arrives the cycle after the request in execute
    assign ms_final     = ms_load ? data_sram_rdata : ms_result;
    assign ms_to_ws_bus = {ms_pc, ms_final, ms_dest_r, ms_gr_we};
    assign ms_dest      = (ms_valid && ms_gr_we) ? ms_dest_r : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

endmodule

//--- wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ms_to_ws_valid,
    input  logic [bus_pkg::MS_WS_W-1:0] ms_to_ws_bus,
    output logic                        ws_allowin,
    output logic [bus_pkg::RF_W-1:0]    rf_bus,
    output logic [cpu_pkg::XLEN-1:0]    debug_wb_pc,
    output logic [3:0]                  debug_wb_rf_we,
    output logic [cpu_pkg::REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [cpu_pkg::XLEN-1:0]    debug_wb_rf_wdata
);

    logic                        ws_valid;
    logic                        rf_we;
    logic [bus_pkg::MS_WS_W-1:0] ws_bus_r;
    logic [cpu_pkg::XLEN-1:0]    ws_pc;
    logic [cpu_pkg::XLEN-1:0]    ws_final;
    logic [cpu_pkg::REG_AW-1:0]  ws_dest;
    logic                        ws_gr_we;

    assign {ws_pc, ws_final, ws_dest, ws_gr_we} = ws_bus_r;

    // last stage, nothing downstream can hold it
    assign ws_allowin  = 1'b1;

    assign rf_we  = ws_valid && ws_gr_we && ws_dest != '0;
    assign rf_bus = {rf_we, ws_dest, ws_final};

    // trace mirrors the register write exactly
    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_final;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    // decode already drops r0 writes, so no trace write can name r0
    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        (ws_valid && ws_gr_we) |-> ws_dest != '0);

endmodule

//--- mycpu_top.sv
`timescale 1ns/10ps

module mycpu_top #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    // inst sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // writeback trace
    output logic [31:0] debug_wb_pc,
    output logic [ 3:0] debug_wb_rf_we,
    output logic [ 4:0] debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                        ds_allowin;
    logic                        es_allowin;
    logic                        ms_allowin;
    logic                        ws_allowin;
    logic                        fs_to_ds_valid;
    logic                        ds_to_es_valid;
    logic                        es_to_ms_valid;
    logic                        ms_to_ws_valid;
    logic [bus_pkg::FS_DS_W-1:0] fs_to_ds_bus;
    logic [bus_pkg::DS_ES_W-1:0] ds_to_es_bus;
    logic [bus_pkg::ES_MS_W-1:0] es_to_ms_bus;
    logic [bus_pkg::MS_WS_W-1:0] ms_to_ws_bus;
    logic [bus_pkg::BR_W-1:0]    br_bus;
    logic [bus_pkg::RF_W-1:0]    rf_bus;
    logic [cpu_pkg::REG_AW-1:0]  es_dest;
    logic [cpu_pkg::REG_AW-1:0]  ms_dest;
    logic [cpu_pkg::REG_AW-1:0]  rf_raddr1;
    logic [cpu_pkg::REG_AW-1:0]  rf_raddr2;
    logic [cpu_pkg::XLEN-1:0]    rf_rdata1;
    logic [cpu_pkg::XLEN-1:0]    rf_rdata2;

    // instruction side is read only
    assign inst_sram_we    = 4'h0;
    assign inst_sram_wdata = '0;

    if_stage #(.RESET_PC(RESET_PC)) if_stage (.*);

    id_stage id_stage (.*);

    regfile regfile (
        .clk    (clk      ),
        .arst_n (arst_n   ),
        .rf_bus (rf_bus   ),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    exe_stage exe_stage (.*);

    mem_stage mem_stage (.*);

    wb_stage wb_stage (.*);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released on a rising edge, like any other driven input
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
    parameter int N_EXP = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    // each entry is {pc, wnum, wdata}
    input  logic [68:0] expected [N_EXP],
    input  logic [3:0]  inst_sram_we,
    input  logic [31:0] inst_sram_wdata,
    input  logic [31:0] debug_wb_pc,
    input  logic [3:0]  debug_wb_rf_we,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    output logic        done,
    output int          n_checked,
    output int          n_errors
);

    int idx    = 0;
    int errors = 0;

    assign done      = (idx == N_EXP);
    assign n_checked = idx;
    assign n_errors  = errors;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h (trace entry %0d)",
                     name, got, want, idx);
            errors++;
        end
    endtask

    // trace outputs settle after the rising edge, look at them mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            // instruction side is never written
            compare_field("inst_sram_we", 32'(inst_sram_we), 32'h0000_0000);
            compare_field("inst_sram_wdata", inst_sram_wdata, 32'h0000_0000);
        end
        if (arst_n && debug_wb_rf_we != 4'h0) begin
            if (idx >= N_EXP) begin
                $display("register write to r%0d at pc 0x%h after the last expected write",
                         debug_wb_rf_wnum, debug_wb_pc);
                errors++;
            end else begin
                compare_field("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'h0000_000f);
                compare_field("debug_wb_pc", debug_wb_pc, expected[idx][68:37]);
                compare_field("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum),
                              32'(expected[idx][36:32]));
                compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, expected[idx][31:0]);
                idx++;
            end
        end
    end

endmodule

//--- tb_top.sv
`timescale 1ns/10ps

module tb_top;

    localparam int PROG_LEN       = 16;
    localparam int N_EXP          = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_WAIT     = 100;
    localparam int DRAIN_CYCLES   = 20;

    // hand assembled, pc = 4 * index
    localparam logic [31:0] PROGRAM [PROG_LEN] = '{
        32'h0280_1401,  // addi.w r1, r0, 5
        32'h02bf_f402,  // addi.w r2, r0, -3
        32'h0010_0823,  // add.w  r3, r1, r2
        32'h0010_0c64,  // add.w  r4, r3, r3
        32'h0284_0085,  // addi.w r5, r4, 0x100
        32'h2981_0005,  // st.w   r5, r0, 0x40
        32'h2881_0006,  // ld.w   r6, r0, 0x40
        32'h0280_1c20,  // addi.w r0, r1, 7
        32'h0010_0407,  // add.w  r7, r0, r1
        32'h5800_0827,  // beq    r1, r7, +8  (taken)
        32'h029f_fc08,  // addi.w r8, r0, 0x7ff  (skipped)
        32'h0280_2409,  // addi.w r9, r0, 9
        32'h5800_0822,  // beq    r1, r2, +8  (not taken)
        32'h0280_052a,  // addi.w r10, r9, 1
        32'h0010_194b,  // add.w  r11, r10, r6
        32'h5800_0000   // beq    r0, r0, 0  (park here)
    };

    // pc, wnum, wdata of every register write, in retirement order
    logic [68:0] expected_trace [N_EXP] = '{
        {32'h0000_0000, 5'd1,  32'h0000_0005},
        {32'h0000_0004, 5'd2,  32'hffff_fffd},
        {32'h0000_0008, 5'd3,  32'h0000_0002},
        {32'h0000_000c, 5'd4,  32'h0000_0004},
        {32'h0000_0010, 5'd5,  32'h0000_0104},
        {32'h0000_0018, 5'd6,  32'h0000_0104},
        {32'h0000_0020, 5'd7,  32'h0000_0005},
        {32'h0000_002c, 5'd9,  32'h0000_0009},
        {32'h0000_0034, 5'd10, 32'h0000_000a},
        {32'h0000_0038, 5'd11, 32'h0000_010e}
    };

    logic        clk;
    logic        arst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = '0;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = '0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        done;
    int          n_checked;
    int          n_errors;
    logic [31:0] rom [256];
    logic [31:0] ram [256];

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mycpu_top #(.RESET_PC(32'h0000_0000)) i_dut (
        .clk               (clk),
        .arst_n            (arst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_checker #(.N_EXP(N_EXP)) trace_checker (
        .clk               (clk),
        .arst_n            (arst_n),
        .expected          (expected_trace),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_wdata   (inst_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (done),
        .n_checked         (n_checked),
        .n_errors          (n_errors)
    );

    // words past the program decode as nothing known, so they retire as no-ops
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i < PROG_LEN) ? PROGRAM[i] : (32'hfc00_0000 | 32'(i));
            ram[i] <= 32'hd0d0_0000 | 32'(i);
        end
    end

    // instruction ROM, data one edge after the request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= rom[inst_sram_addr[9:2]];
        end
    end

    // data RAM with byte enables, read returns the old word
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    ram[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
            data_sram_rdata <= ram[data_sram_addr[9:2]];
        end
    end

    initial begin
        int cycles;
        int extra_errors;

        cycles       = 0;
        extra_errors = 0;
        while (arst_n !== 1'b1 && cycles < RESET_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            extra_errors++;
        end

        cycles = 0;
        while (arst_n && !done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout after %0d cycles, only %0d of %0d writes seen",
                     cycles, n_checked, N_EXP);
            extra_errors++;
        end else begin
            // core parks on the final beq, any write from here on is wrong
            cycles = 0;
            while (cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
        end

        $display("writes checked: %0d of %0d, errors: %0d",
                 n_checked, N_EXP, n_errors + extra_errors);
        if (n_errors == 0 && extra_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
cpu_pkg.sv
bus_pkg.sv
if_stage.sv
id_stage.sv
regfile.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
mycpu_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
